// File: source/mipsIsaPkg.sv
package mipsIsaPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic widths of the instruction set
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;      // One data word
  typedef logic [4:0]  regIdx_t;    // Register number
  typedef logic [31:0] instAddr_t;  // Byte address of an instruction

  // Opcodes of the supported subset
  typedef enum logic [5:0] {
    opRType = 6'h00,  // Function field decides
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opBne   = 6'h05,
    opAddiu = 6'h09,
    opAndi  = 6'h0c,
    opOri   = 6'h0d,
    opLui   = 6'h0f,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcode_e;

  // R-type function codes
  typedef enum logic [5:0] {
    fnSll  = 6'h00,
    fnAddu = 6'h21,
    fnSubu = 6'h23,
    fnAnd  = 6'h24,
    fnOr   = 6'h25,
    fnSlt  = 6'h2a
  } funct_e;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluLui
  } aluOp_e;

  ////////////////////////////////////////////////////////////////////////////
  // Control word out of the decoder
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic   regDst;    // Write rd instead of rt
    logic   aluSrc;    // Second operand is the immediate
    logic   memToReg;  // Write back load data
    logic   regWrite;
    logic   memWrite;
    logic   branch;    // beq
    logic   nBranch;   // bne
    logic   jmp;
    logic   jal;       // Jump and link to r31
    logic   zeroExt;   // andi, ori
    aluOp_e aluOp;
  } ctrl_t;

endpackage

// File: source/socBusPkg.sv
package socBusPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone loader port
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [14:0] wbAddr_t;   // Word address, bit 14 picks the memory
  typedef logic [13:0] memIdx_t;   // Word index inside one memory
  typedef logic [31:0] wbData_t;

  localparam int unsigned memSelBit = 14;  // Address bit of memory select

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;   // High for write
    wbAddr_t adr;
    wbData_t dat;  // Write data
  } wbReq_t;

  typedef struct packed {
    logic    ack;
    wbData_t dat;  // Read data, valid with ack
  } wbRsp_t;

  typedef enum logic {
    selImem = 1'b0,
    selDmem = 1'b1
  } memSel_t;

  // Loader write toward either memory
  typedef struct packed {
    logic    en;
    memSel_t sel;
    memIdx_t idx;
    wbData_t dat;
  } memPort_t;

endpackage

// File: source/loadControl.sv
module loadControl (
  input  logic                fpga_clk,
  input  logic                fpga_rst,
  input  logic                start,
  input  logic                stop,
  input  socBusPkg::wbReq_t   wbReq,
  output socBusPkg::wbRsp_t   wbRsp,
  input  mipsIsaPkg::word_t   imemRdata,
  input  mipsIsaPkg::word_t   dmemRdata,
  output socBusPkg::memPort_t memPort,
  output socBusPkg::wbAddr_t  loadAdr,
  output logic                coreRst
);
  import socBusPkg::*;

  typedef enum logic {
    stLoad,  // Core held, bus served
    stRun    // Core executing, bus stalled
  } mode_e;

  mode_e   mode;
  mode_e   modeNext;
  logic    accept;    // Request taken this cycle
  logic    ackQ;
  memSel_t reqSel;

  ////////////////////////////////////////////////////////////////////////////
  // Load / run mode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    modeNext = mode;
    case (mode)
      stLoad:  if (start) modeNext = stRun;
      stRun:   if (stop) modeNext = stLoad;
      default: modeNext = stLoad;
    endcase
  end

  always_ff @(posedge fpga_clk) begin
    if (fpga_rst) begin
      mode <= stLoad;
      ackQ <= 1'b0;
    end else begin
      mode <= modeNext;
      ackQ <= accept;  // One ack per request
    end
  end

  // Core sits in reset for the whole load phase
  assign coreRst = (mode == stLoad);

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone slave
  ////////////////////////////////////////////////////////////////////////////

  // Gap after ack keeps a held request from a second ack
  assign accept = (mode == stLoad) && wbReq.cyc && wbReq.stb && !ackQ;
  assign reqSel = memSel_t'(wbReq.adr[memSelBit]);

  assign memPort.en  = accept && wbReq.we;  // Write lands with the ack edge
  assign memPort.sel = reqSel;
  assign memPort.idx = wbReq.adr[memSelBit-1:0];
  assign memPort.dat = wbReq.dat;
  assign loadAdr     = wbReq.adr;         // Read address to both memories

  assign wbRsp.ack = ackQ;
  assign wbRsp.dat = (reqSel == selDmem) ? dmemRdata : imemRdata;

  // Master holds the request until ack, so ack always meets a live strobe
  ackNeedsStb: assert property (@(posedge fpga_clk) disable iff (fpga_rst)
    wbRsp.ack |-> (wbReq.cyc && wbReq.stb));

endmodule

// File: source/instFetch.sv
module instFetch #(
  parameter int unsigned imemWords = 256
) (
  input  logic                  fpga_clk,
  input  logic                  coreRst,
  input  socBusPkg::memPort_t   memPort,
  input  socBusPkg::wbAddr_t    loadAdr,
  input  mipsIsaPkg::ctrl_t     ctrl,
  input  logic                  zero,
  input  mipsIsaPkg::instAddr_t branchTarget,
  output mipsIsaPkg::word_t     instr,
  output mipsIsaPkg::instAddr_t pcPlus4,
  output mipsIsaPkg::instAddr_t pc,
  output mipsIsaPkg::word_t     loadRdata
);
  import mipsIsaPkg::*;
  import socBusPkg::*;

  localparam int unsigned imemAw = $clog2(imemWords);

  word_t     imem [imemWords];
  instAddr_t jumpTarget;
  instAddr_t pcNext;
  logic      takeBranch;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction memory
  ////////////////////////////////////////////////////////////////////////////

  // Only the loader writes, core side is read only
  always_ff @(posedge fpga_clk) begin
    if (memPort.en && memPort.sel == selImem) begin
      imem[memPort.idx[imemAw-1:0]] <= memPort.dat;
    end
  end

  assign instr     = imem[pc[imemAw+1:2]];     // Word index from byte PC
  assign loadRdata = imem[loadAdr[imemAw-1:0]];  // Loader read port

  ////////////////////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////////////////////

  assign pcPlus4    = pc + 32'd4;
  assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};  // Region of PC+4
  assign takeBranch = (ctrl.branch && zero) || (ctrl.nBranch && !zero);

  always_comb begin
    if (ctrl.jmp || ctrl.jal) begin
      pcNext = jumpTarget;
    end else if (takeBranch) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (coreRst) begin
      pc <= '0;  // Restart at address 0
    end else begin
      pc <= pcNext;
    end
  end

  // Branch offsets from the ALU are word multiples
  pcAligned: assert property (@(posedge fpga_clk) disable iff (coreRst)
    pc[1:0] == 2'b00);

endmodule

// File: source/instDecode.sv
module instDecode (
  input  logic                  fpga_clk,
  input  logic                  coreRst,
  input  mipsIsaPkg::word_t     instr,
  input  mipsIsaPkg::word_t     aluResult,
  input  mipsIsaPkg::word_t     memRdata,
  input  mipsIsaPkg::instAddr_t pcPlus4,
  output mipsIsaPkg::ctrl_t     ctrl,
  output mipsIsaPkg::word_t     rs,
  output mipsIsaPkg::word_t     rt,
  output mipsIsaPkg::word_t     imm
);
  import mipsIsaPkg::*;

  opcode_e opcode;
  funct_e  funct;
  regIdx_t rsIdx;
  regIdx_t rtIdx;
  regIdx_t rdIdx;
  regIdx_t wrIdx;
  word_t   wrData;
  word_t   regs [32];

  assign opcode = opcode_e'(instr[31:26]);
  assign funct  = funct_e'(instr[5:0]);
  assign rsIdx  = instr[25:21];
  assign rtIdx  = instr[20:16];
  assign rdIdx  = instr[15:11];

  ////////////////////////////////////////////////////////////////////////////
  // Control decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl       = '0;      // Default no-op
    ctrl.aluOp = aluAdd;
    case (opcode)
      opRType: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          fnAddu:  ctrl.aluOp = aluAdd;
          fnSubu:  ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          fnSll:   ctrl.aluOp = aluSll;
          default: ctrl.regWrite = 1'b0;  // Unknown function
        endcase
      end
      opAddiu: {ctrl.aluSrc, ctrl.regWrite} = 2'b11;
      opAndi: begin
        {ctrl.aluSrc, ctrl.regWrite, ctrl.zeroExt} = 3'b111;
        ctrl.aluOp = aluAnd;
      end
      opOri: begin
        {ctrl.aluSrc, ctrl.regWrite, ctrl.zeroExt} = 3'b111;
        ctrl.aluOp = aluOr;
      end
      opLui: begin
        {ctrl.aluSrc, ctrl.regWrite} = 2'b11;
        ctrl.aluOp = aluLui;
      end
      opLw:  {ctrl.aluSrc, ctrl.memToReg, ctrl.regWrite} = 3'b111;
      opSw:  {ctrl.aluSrc, ctrl.memWrite} = 2'b11;  // Address is rs + imm
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;  // Zero flag compares rs and rt
      end
      opBne: begin
        ctrl.nBranch = 1'b1;
        ctrl.aluOp   = aluSub;
      end
      opJ:   ctrl.jmp = 1'b1;
      opJal: {ctrl.jal, ctrl.regWrite} = 2'b11;
      default: ;  // Unknown opcode stays a no-op
    endcase
    // Held core must not disturb memory being loaded
    if (coreRst) begin
      ctrl.regWrite = 1'b0;
      ctrl.memWrite = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file and write-back
  ////////////////////////////////////////////////////////////////////////////

  assign wrIdx  = ctrl.jal ? 5'd31 : (ctrl.regDst ? rdIdx : rtIdx);
  assign wrData = ctrl.jal ? pcPlus4 : (ctrl.memToReg ? memRdata : aluResult);

  always_ff @(posedge fpga_clk) begin
    if (coreRst) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (ctrl.regWrite && wrIdx != '0) begin  // r0 never written
      regs[wrIdx] <= wrData;
    end
  end

  assign rs = regs[rsIdx];
  assign rt = regs[rtIdx];

  // Zero extension only for andi and ori
  assign imm = ctrl.zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

  // Register 0 reads zero on both ports
  r0ReadsZero: assert property (@(posedge fpga_clk) disable iff (coreRst)
    (rsIdx != '0 || rs == '0) && (rtIdx != '0 || rt == '0));

endmodule

// File: source/aluExecute.sv
module aluExecute (
  input  mipsIsaPkg::ctrl_t     ctrl,
  input  mipsIsaPkg::word_t     rs,
  input  mipsIsaPkg::word_t     rt,
  input  mipsIsaPkg::word_t     imm,
  input  mipsIsaPkg::instAddr_t pcPlus4,
  output mipsIsaPkg::word_t     result,
  output logic                  zero,
  output mipsIsaPkg::instAddr_t branchTarget
);
  import mipsIsaPkg::*;

  word_t      opB;
  logic [4:0] shamt;

  ////////////////////////////////////////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////////////////////////////////////////

  assign opB   = ctrl.aluSrc ? imm : rt;
  assign shamt = imm[10:6];  // sll shift amount sits inside the immediate

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.aluOp)
      aluAdd: result = rs + opB;  // addu, addiu, lw, sw
      aluSub: result = rs - opB;  // subu, beq, bne
      aluAnd: result = rs & opB;
      aluOr:  result = rs | opB;
      aluSlt: begin
        result = '0;
        result[0] = $signed(rs) < $signed(opB);  // Signed compare
      end
      aluSll: result = rt << shamt;
      aluLui: result = {opB[15:0], 16'h0000};    // Upper half load
      default: result = rs + opB;
    endcase
  end

  assign zero = (result == '0);

  // Branch offset counts words from PC+4
  assign branchTarget = pcPlus4 + {imm[29:0], 2'b00};

endmodule

// File: source/dataMemory.sv
module dataMemory #(
  parameter int unsigned dmemWords = 256
) (
  input  logic                fpga_clk,
  input  mipsIsaPkg::ctrl_t   ctrl,
  input  mipsIsaPkg::word_t   addr,
  input  mipsIsaPkg::word_t   wdata,
  output mipsIsaPkg::word_t   rdata,
  input  socBusPkg::memPort_t memPort,
  input  socBusPkg::wbAddr_t  loadAdr,
  output mipsIsaPkg::word_t   loadRdata
);
  import mipsIsaPkg::*;
  import socBusPkg::*;

  localparam int unsigned dmemAw = $clog2(dmemWords);

  word_t             mem [dmemWords];
  logic              loadWr;   // Loader write to this memory
  logic [dmemAw-1:0] coreIdx;

  assign coreIdx = addr[dmemAw+1:2];  // Byte address to word index
  assign loadWr  = memPort.en && memPort.sel == selDmem;

  always_ff @(posedge fpga_clk) begin
    if (ctrl.memWrite) begin
      mem[coreIdx] <= wdata;
    end else if (loadWr) begin
      mem[memPort.idx[dmemAw-1:0]] <= memPort.dat;
    end
  end

  assign rdata     = mem[coreIdx];                // Combinational load
  assign loadRdata = mem[loadAdr[dmemAw-1:0]];  // Bus read port

  // Loader only writes while the core is held
  onePortWrites: assert property (@(posedge fpga_clk)
    !(ctrl.memWrite && loadWr));

endmodule

// File: source/cpuTop.sv
module cpuTop #(
  parameter int unsigned imemWords = 256,
  parameter int unsigned dmemWords = 256
) (
  input  logic              fpga_clk,
  input  logic              fpga_rst,  // Active high
  input  logic              start,     // Leave loading, run program
  input  logic              stop,      // Back to loading
  input  socBusPkg::wbReq_t wbReq,
  output socBusPkg::wbRsp_t wbRsp,
  output mipsIsaPkg::word_t debugPc    // Address executing this cycle
);
  import mipsIsaPkg::*;
  import socBusPkg::*;

  // Loader side
  memPort_t  memPort;
  wbAddr_t   loadAdr;
  logic      coreRst;
  word_t     imemRdata;
  word_t     dmemRdata;

  // Core data path
  ctrl_t     ctrl;
  word_t     instr;
  instAddr_t pcPlus4;
  instAddr_t branchTarget;
  logic      zero;
  word_t     rs;
  word_t     rt;
  word_t     imm;
  word_t     aluResult;
  word_t     memRdata;

  loadControl uLoad (
    .fpga_clk, .fpga_rst, .start, .stop, .wbReq, .wbRsp,
    .imemRdata, .dmemRdata, .memPort, .loadAdr, .coreRst
  );

  instFetch #(.imemWords(imemWords)) uFetch (
    .fpga_clk, .coreRst, .memPort, .loadAdr, .ctrl, .zero, .branchTarget,
    .instr, .pcPlus4, .pc(debugPc), .loadRdata(imemRdata)
  );

  instDecode uDecode (
    .fpga_clk, .coreRst, .instr, .aluResult, .memRdata, .pcPlus4,
    .ctrl, .rs, .rt, .imm
  );

  aluExecute uExec (
    .ctrl, .rs, .rt, .imm, .pcPlus4, .result(aluResult), .zero, .branchTarget
  );

  dataMemory #(.dmemWords(dmemWords)) uDmem (
    .fpga_clk, .ctrl, .addr(aluResult), .wdata(rt), .rdata(memRdata),
    .memPort, .loadAdr, .loadRdata(dmemRdata)
  );

endmodule

// File: tb/clockGen.sv
module clockGen (
  input  logic rstReq,    // Extra reset pulse from the test sequence
  output logic fpga_clk,
  output logic fpga_rst
);
  timeunit 1ns;
  timeprecision 1ns;

  logic porRst;  // Power-on reset

  initial begin
    fpga_clk = 1'b0;
    forever #50 fpga_clk = ~fpga_clk;  // 100 ns period
  end

  initial begin
    porRst = 1'b1;
    repeat (3) @(posedge fpga_clk);
    porRst <= 1'b0;  // Held for 3 rising edges
  end

  assign fpga_rst = porRst | rstReq;

endmodule

// File: tb/cpuTb.sv
module cpuTb;
  timeunit 1ns;
  timeprecision 1ns;
  import mipsIsaPkg::*;
  import socBusPkg::*;

  localparam int imemWords = 256;
  localparam int dmemWords = 256;
  localparam int maxBody   = 20;   // Random instructions before the store epilogue
  localparam int maxProg   = maxBody + 33;
  localparam int progCount = 16;   // Programs run after the loader test
  localparam int busLimit  = 2000; // Cycles a stalled bus access may wait
  localparam int kindAlu   = 0;
  localparam int kindMem   = 1;
  localparam int kindCtrl  = 2;

  // Load, run and readback of one program, plus the loader round trip
  localparam int progCycles   = maxProg + 4 + 3 * (2 * maxProg + 64 + dmemWords);
  localparam int loaderCycles = 3 * 2 * (imemWords + dmemWords);
  localparam longint watchdogNs = 64'(2 * (progCount * progCycles + loaderCycles)) * 100;

  logic   fpga_clk;
  logic   fpga_rst;
  logic   rstReq;
  logic   start;
  logic   stop;
  wbReq_t wbReq;
  wbRsp_t wbRsp;
  word_t  debugPc;

  // Reference model state
  word_t mRegs [32];
  word_t mImem [imemWords];
  word_t mDmem [dmemWords];
  word_t mPc;
  word_t prog [imemWords];
  int    progLen;

  word_t seed;
  int    errors;
  int    checks;
  int    accesses;   // Bus accesses issued
  int    acksSeen;   // Ack cycles observed
  logic  running;    // Core in Run state

  clockGen uClk (.rstReq, .fpga_clk, .fpga_rst);

  cpuTop #(.imemWords(imemWords), .dmemWords(dmemWords)) uut (
    .fpga_clk, .fpga_rst, .start, .stop, .wbReq, .wbRsp, .debugPc
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and instruction encoding
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
    return seed;
  endfunction

  function automatic int randBelow(input int n);
    word_t r;
    r = nextRand();
    return int'(r[30:8]) % n;  // Upper bits, low ones cycle fast
  endfunction

  function automatic word_t encR(input int rs, rt, rd, sh, input logic [5:0] fn);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic word_t encI(input logic [5:0] op, input int rs, rt,
                                 input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic word_t encJ(input logic [5:0] op, input int target);
    return {op, 26'(target)};  // Word index of the target
  endfunction

  function automatic wbAddr_t imemAdr(input int i);
    return {1'b0, 14'(i)};
  endfunction

  function automatic wbAddr_t dmemAdr(input int i);
    return {1'b1, 14'(i)};  // Bit 14 selects data memory
  endfunction

  // Any ALU or immediate instruction on any register
  function automatic word_t aluInstr();
    word_t       ins;
    word_t       r;
    int          rs;
    int          rt;
    int          rd;
    logic [15:0] imm;
    r   = nextRand();
    imm = r[15:0];
    rs  = randBelow(32);
    rt  = randBelow(32);
    rd  = randBelow(32);
    case (randBelow(10))
      0: ins = encR(rs, rt, rd, 0, 6'h21);               // addu
      1: ins = encR(rs, rt, rd, 0, 6'h23);               // subu
      2: ins = encR(rs, rt, rd, 0, 6'h24);               // and
      3: ins = encR(rs, rt, rd, 0, 6'h25);               // or
      4: ins = encR(rs, rt, rd, 0, 6'h2a);               // slt
      5: ins = encR(0, rt, rd, randBelow(32), 6'h00);    // sll
      6: ins = encI(6'h09, rs, rt, imm);                 // addiu
      7: ins = encI(6'h0c, rs, rt, imm);                 // andi
      8: ins = encI(6'h0d, rs, rt, imm);                 // ori
      default: ins = encI(6'h0f, 0, rt, imm);            // lui
    endcase
    return ins;
  endfunction

  // Body instruction at index p, branch and jump targets only go forward
  function automatic word_t bodyInstr(input int kind, input int p, input int bodyLen);
    word_t ins;
    int    t;
    int    ra;
    int    rb;
    t  = p + 1 + randBelow(bodyLen - p);  // In (p, bodyLen]
    ra = 1 + randBelow(7);                // Few registers, equal values likely
    rb = 1 + randBelow(7);
    if (kind == kindAlu) begin
      ins = aluInstr();
    end else if (kind == kindMem) begin
      case (randBelow(4))
        0:       ins = aluInstr();
        1:       ins = encI(6'h2b, 0, randBelow(32), 16'(4 * randBelow(64)));  // sw
        default: ins = encI(6'h23, 0, randBelow(32), 16'(4 * randBelow(64)));  // lw
      endcase
    end else begin
      case (randBelow(6))
        0:       ins = encI(6'h09, 0, ra, 16'(randBelow(3)));
        1:       ins = encR(ra, rb, 1 + randBelow(7), 0, 6'h21);
        2:       ins = encI(6'h04, ra, rb, 16'(t - p - 1));   // beq
        3:       ins = encI(6'h05, ra, rb, 16'(t - p - 1));   // bne
        4:       ins = encJ(6'h02, t);
        default: ins = encJ(6'h03, t);                        // jal
      endcase
    end
    return ins;
  endfunction

  // Body, then sw of r0..r31 to words 128..159, then a self-jump
  task automatic genProgram(input int kind, input int bodyLen);
    for (int p = 0; p < bodyLen; p++)
      prog[p] = bodyInstr(kind, p, bodyLen);
    for (int r = 0; r < 32; r++)
      prog[bodyLen + r] = encI(6'h2b, 0, r, 16'(512 + 4 * r));
    prog[bodyLen + 32] = encJ(6'h02, bodyLen + 32);
    progLen = bodyLen + 33;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference ISA model
  ////////////////////////////////////////////////////////////////////////////

  task automatic setReg(input int idx, input word_t v);
    if (idx != 0) mRegs[idx] = v;  // r0 hardwired
  endtask

  task automatic modelStep();
    word_t ins;
    word_t a;
    word_t b;
    word_t sx;
    word_t zx;
    word_t adr;
    word_t nextPc;
    int    rsI;
    int    rtI;
    int    rdI;
    ins    = mImem[mPc[9:2]];
    rsI    = int'(ins[25:21]);
    rtI    = int'(ins[20:16]);
    rdI    = int'(ins[15:11]);
    a      = mRegs[rsI];
    b      = mRegs[rtI];
    sx     = {{16{ins[15]}}, ins[15:0]};
    zx     = {16'h0000, ins[15:0]};
    adr    = a + sx;          // lw, sw effective address
    nextPc = mPc + 32'd4;
    case (ins[31:26])
      6'h00: begin
        case (ins[5:0])
          6'h21: setReg(rdI, a + b);
          6'h23: setReg(rdI, a - b);
          6'h24: setReg(rdI, a & b);
          6'h25: setReg(rdI, a | b);
          6'h2a: setReg(rdI, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
          6'h00: setReg(rdI, b << ins[10:6]);
          default: ;
        endcase
      end
      6'h09: setReg(rtI, adr);
      6'h0c: setReg(rtI, a & zx);
      6'h0d: setReg(rtI, a | zx);
      6'h0f: setReg(rtI, {ins[15:0], 16'h0000});
      6'h23: setReg(rtI, mDmem[adr[9:2]]);
      6'h2b: mDmem[adr[9:2]] = b;
      6'h04: if (a == b) nextPc = mPc + 32'd4 + {sx[29:0], 2'b00};
      6'h05: if (a != b) nextPc = mPc + 32'd4 + {sx[29:0], 2'b00};
      6'h02: nextPc = {nextPc[31:28], ins[25:0], 2'b00};
      6'h03: begin
        setReg(31, mPc + 32'd4);  // Link
        nextPc = {nextPc[31:28], ins[25:0], 2'b00};
      end
      default: ;
    endcase
    mPc = nextPc;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks and Wishbone master
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic busAccess(input logic we, input wbAddr_t adr, input word_t wdat,
                           output word_t rdat);
    wbReq_t req;
    int     waited;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    waited  = 0;
    @(posedge fpga_clk);
    wbReq <= req;  // Held until ack
    @(negedge fpga_clk);
    while (!wbRsp.ack && waited < busLimit) begin
      waited++;
      @(negedge fpga_clk);
    end
    if (wbRsp.ack) begin
      rdat = wbRsp.dat;
    end else begin
      errors++;
      rdat = 'x;
      $display("Bus access to address %h was never acknowledged", adr);
    end
    accesses++;
    @(posedge fpga_clk);
    wbReq <= '0;
  endtask

  task automatic busWrite(input wbAddr_t adr, input word_t dat);
    word_t ignored;
    busAccess(1'b1, adr, dat, ignored);
  endtask

  task automatic busRead(input wbAddr_t adr, output word_t dat);
    busAccess(1'b0, adr, '0, dat);
  endtask

  // Every ack cycle counted, none allowed while the core runs
  always @(negedge fpga_clk) begin
    if (wbRsp.ack) begin
      acksSeen++;
      if (running) begin
        errors++;
        $display("Bus acknowledged a request while the core was running");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Program load, run and readback
  ////////////////////////////////////////////////////////////////////////////

  task automatic loadProgram();
    for (int i = 0; i < progLen; i++) begin
      busWrite(imemAdr(i), prog[i]);
      mImem[i] = prog[i];
    end
  endtask

  // Runs the given number of instructions, ended by stop or by fpga_rst
  task automatic runProgram(input int cycles, input logic endByReset);
    mPc = '0;
    for (int r = 0; r < 32; r++)
      mRegs[r] = '0;           // Core reset clears all registers
    @(posedge fpga_clk);
    start <= 1'b1;
    @(posedge fpga_clk);
    start   <= 1'b0;           // Run from this edge on
    running = 1'b1;
    for (int i = 0; i < cycles; i++) begin
      if (i == cycles - 1) begin
        if (endByReset) rstReq <= 1'b1;
        else stop <= 1'b1;     // Last instruction still retires
      end
      @(negedge fpga_clk);
      checkValue("debugPc", debugPc, mPc);
      modelStep();
      @(posedge fpga_clk);
    end
    running = 1'b0;
    stop    <= 1'b0;
    if (endByReset) begin
      repeat (2) @(posedge fpga_clk);
      rstReq <= 1'b0;          // 3 cycles of reset
    end
  endtask

  task automatic compareDmem();
    word_t got;
    for (int i = 0; i < dmemWords; i++) begin
      busRead(dmemAdr(i), got);
      checkValue($sformatf("dmem[%0d]", i), got, mDmem[i]);
    end
  endtask

  task automatic testProgram(input int kind, input int bodyLen, input logic endByReset);
    word_t val;
    genProgram(kind, bodyLen);
    if (kind == kindMem) begin
      for (int i = 0; i < 64; i++) begin  // Preload words that lw reads
        val = nextRand();
        busWrite(dmemAdr(i), val);
        mDmem[i] = val;
      end
    end
    loadProgram();
    runProgram(progLen + 4, endByReset);
    compareDmem();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic loaderRoundTrip();
    word_t val;
    word_t got;
    int    ackBase;
    int    accBase;
    ackBase = acksSeen;
    accBase = accesses;
    for (int i = 0; i < imemWords; i++) begin
      val = nextRand();
      busWrite(imemAdr(i), val);
      mImem[i] = val;
    end
    for (int i = 0; i < dmemWords; i++) begin
      val = nextRand();
      busWrite(dmemAdr(i), val);
      mDmem[i] = val;
    end
    for (int i = 0; i < imemWords; i++) begin
      busRead(imemAdr(i), got);
      checkValue($sformatf("imem[%0d]", i), got, mImem[i]);
    end
    compareDmem();
    checkValue("loader ack count", word_t'(acksSeen - ackBase), word_t'(accesses - accBase));
  endtask

  // Request issued in Run must wait for stop
  task automatic backPressure();
    word_t got;
    genProgram(kindAlu, maxBody);
    loadProgram();
    fork
      runProgram(progLen + 4, 1'b0);
      begin
        repeat (4) @(posedge fpga_clk);
        busRead(imemAdr(3), got);
      end
    join
    checkValue("stalled imem read", got, prog[3]);
    compareDmem();
    for (int i = 0; i < progLen; i++) begin  // Core never writes imem
      busRead(imemAdr(i), got);
      checkValue($sformatf("imem[%0d]", i), got, prog[i]);
    end
  endtask

  task automatic resetRestart();
    testProgram(kindAlu, 12, 1'b0);
    testProgram(kindAlu, 0, 1'b0);   // Re-entry, stores show zero registers
    testProgram(kindAlu, 12, 1'b1);  // Ended by fpga_rst
    testProgram(kindAlu, 0, 1'b0);
  endtask

  initial begin
    seed     = 32'h773f;
    errors   = 0;
    checks   = 0;
    accesses = 0;
    acksSeen = 0;
    running  = 1'b0;
    rstReq   = 1'b0;
    start    = 1'b0;
    stop     = 1'b0;
    wbReq    = '0;
    @(negedge fpga_clk);
    while (fpga_rst !== 1'b0) @(negedge fpga_clk);

    loaderRoundTrip();
    for (int n = 0; n < 4; n++) testProgram(kindAlu, maxBody, 1'b0);
    for (int n = 0; n < 3; n++) testProgram(kindMem, maxBody, 1'b0);
    for (int n = 0; n < 4; n++) testProgram(kindCtrl, maxBody, 1'b0);
    backPressure();
    resetRestart();
    checkValue("total ack count", word_t'(acksSeen), word_t'(accesses));

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Run time bound from test lengths, doubled
  initial begin
    #(watchdogNs);
    $display("Watchdog expired before the tests completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: mipsCore.f
source/mipsIsaPkg.sv
source/socBusPkg.sv
source/loadControl.sv
source/instFetch.sv
source/instDecode.sv
source/aluExecute.sv
source/dataMemory.sv
source/cpuTop.sv
tb/clockGen.sv
tb/cpuTb.sv

// File: runSim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
  --top-module cpuTb -f mipsCore.f
./obj_dir/VcpuTb | tee sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
  echo "Run passed"
else
  echo "Run failed, see sim.log"
  exit 1
fi
